// ==== verilog/sdram_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// sdram device definitions: command and state encodings, pin widths and
// cycle counts derived from the clock frequency and device timings
////////////////////////////////////////////////////////////////////////////

package sdram_pkg;

  // command value is {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_load_mode    = 4'b0000,
    cmd_auto_refresh = 4'b0001,
    cmd_precharge    = 4'b0010,
    cmd_active       = 4'b0011,
    cmd_write        = 4'b0100,
    cmd_read         = 4'b0101,
    cmd_nop          = 4'b0111,
    cmd_deselect     = 4'b1111
  } sdram_cmd_e;

  // controller states
  typedef enum logic [2:0] {
    st_init,
    st_mode,
    st_idle,
    st_active,
    st_read,
    st_write,
    st_refresh
  } ctrl_state_e;

  // device pins and address fields, x16 part with 4 banks
  localparam int sdram_addr_width = 13;
  localparam int sdram_data_width = 16;
  localparam int sdram_bank_width = 2;
  localparam int sdram_col_width  = 10;
  localparam int sdram_row_width  = 13;
  localparam int dev_addr_width   = sdram_col_width + sdram_row_width + sdram_bank_width;

  // read latency and beats per access
  localparam int cas_latency  = 2;
  localparam int burst_length = 2;

  // mode register: burst write, cl 2, sequential burst of two
  localparam logic [sdram_addr_width-1:0] mode_reg = {
    3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'($clog2(burst_length))
  };

  // a10 high selects all banks for precharge
  localparam logic [sdram_addr_width-1:0] precharge_all_a = sdram_addr_width'(1 << 10);

  localparam int clk_freq_mhz  = 50;
  localparam int clk_period_ns = 1000 / clk_freq_mhz;

  // device times in ns
  localparam int t_desl_ns = 100000;
  localparam int t_mrd_ns  = 14;
  localparam int t_rc_ns   = 60;
  localparam int t_rcd_ns  = 15;
  localparam int t_rp_ns   = 15;
  localparam int t_wr_ns   = 15;
  localparam int t_refi_ns = 7800;

  // cycle counts, rounded up
  localparam int init_wait      = (t_desl_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int load_mode_wait = (t_mrd_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int active_wait    = (t_rcd_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int refresh_wait   = (t_rc_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int precharge_wait = (t_rp_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int read_wait      = cas_latency + burst_length;
  localparam int write_wait     =
      burst_length + (t_wr_ns + t_rp_ns + clk_period_ns - 1) / clk_period_ns;
  // a few cycles of margin, an access may be running when the interval expires
  localparam int refresh_interval = t_refi_ns / clk_period_ns - 10;

  localparam int wait_cnt_width    = 14;
  localparam int refresh_cnt_width = 10;

endpackage

// ==== verilog/mem_port_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// client port definitions shared by the arbiter, controller and top level
////////////////////////////////////////////////////////////////////////////

package mem_port_pkg;

  // two peer clients
  localparam int num_ports = 2;

  // 32-bit word address, 16M words
  localparam int addr_width = 24;

  localparam int data_width = 32;

  // selects one client port
  typedef logic [$clog2(num_ports)-1:0] port_id_t;

endpackage

// ==== verilog/sdram_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// sdram controller: power-up init, periodic auto-refresh and one 32-bit
// access at a time as active plus a two-beat read or write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdram_ctrl (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   req,
  input  logic                                   we,
  input  logic [mem_port_pkg::addr_width-1:0]    addr,
  input  logic [mem_port_pkg::data_width-1:0]    data,
  output logic                                   ack,
  output logic                                   valid,
  output logic [mem_port_pkg::data_width-1:0]    q,
  output logic [sdram_pkg::sdram_addr_width-1:0] sdram_a,
  output logic [sdram_pkg::sdram_bank_width-1:0] sdram_ba,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  output logic                                   sdram_cke,
  output logic                                   sdram_cs_n,
  output logic                                   sdram_ras_n,
  output logic                                   sdram_cas_n,
  output logic                                   sdram_we_n
);

  sdram_pkg::ctrl_state_e state, next_state;
  sdram_pkg::sdram_cmd_e  cmd, next_cmd;

  logic [sdram_pkg::wait_cnt_width-1:0]    wait_counter;
  logic [sdram_pkg::refresh_cnt_width-1:0] refresh_counter;

  // request latch
  logic [sdram_pkg::dev_addr_width-1:0] addr_reg;
  logic [mem_port_pkg::data_width-1:0]  data_reg;
  logic                                 we_reg;
  logic [mem_port_pkg::data_width-1:0]  q_reg;

  logic start;
  logic load_mode_done;
  logic active_done;
  logic refresh_done;
  logic first_word;
  logic read_done;
  logic write_done;
  logic access_done;
  logic should_refresh;
  logic dq_oe;
  logic [sdram_pkg::sdram_data_width-1:0] dq_out;

  // address fields
  logic [sdram_pkg::sdram_col_width-1:0]  col;
  logic [sdram_pkg::sdram_row_width-1:0]  row;
  logic [sdram_pkg::sdram_bank_width-1:0] bank;

  assign col  = addr_reg[sdram_pkg::sdram_col_width-1:0];
  assign row  = addr_reg[sdram_pkg::sdram_col_width+sdram_pkg::sdram_row_width-1:
                         sdram_pkg::sdram_col_width];
  assign bank = addr_reg[sdram_pkg::dev_addr_width-1:
                         sdram_pkg::sdram_col_width+sdram_pkg::sdram_row_width];

  // end-of-wait strobes
  assign load_mode_done = int'(wait_counter) == sdram_pkg::load_mode_wait - 1;
  assign active_done    = int'(wait_counter) == sdram_pkg::active_wait - 1;
  assign refresh_done   = int'(wait_counter) == sdram_pkg::refresh_wait - 1;
  assign first_word     = int'(wait_counter) == sdram_pkg::cas_latency;
  assign read_done      = int'(wait_counter) == sdram_pkg::read_wait - 1;
  assign write_done     = int'(wait_counter) == sdram_pkg::write_wait - 1;
  assign access_done    = (state == sdram_pkg::st_read && read_done) ||
                          (state == sdram_pkg::st_write && write_done);

  assign should_refresh = int'(refresh_counter) >= sdram_pkg::refresh_interval - 1;

  // a new request is taken in idle or at the end of any busy state
  assign start = (state == sdram_pkg::st_idle) || access_done ||
                 (state == sdram_pkg::st_refresh && refresh_done);

  always_comb begin
    next_state = state;
    // nop unless a command is due
    next_cmd   = sdram_pkg::cmd_nop;
    case (state)
      sdram_pkg::st_init: begin
        // deselect, precharge all, two refreshes, then load mode
        if (wait_counter == '0) begin
          next_cmd = sdram_pkg::cmd_deselect;
        end
        if (int'(wait_counter) == sdram_pkg::init_wait - 1) begin
          next_cmd = sdram_pkg::cmd_precharge;
        end
        if (int'(wait_counter) == sdram_pkg::init_wait + sdram_pkg::precharge_wait - 1) begin
          next_cmd = sdram_pkg::cmd_auto_refresh;
        end
        if (int'(wait_counter) == sdram_pkg::init_wait + sdram_pkg::precharge_wait +
            sdram_pkg::refresh_wait - 1) begin
          next_cmd = sdram_pkg::cmd_auto_refresh;
        end
        if (int'(wait_counter) == sdram_pkg::init_wait + sdram_pkg::precharge_wait +
            2 * sdram_pkg::refresh_wait - 1) begin
          next_state = sdram_pkg::st_mode;
          next_cmd   = sdram_pkg::cmd_load_mode;
        end
      end
      sdram_pkg::st_mode: begin
        if (load_mode_done) begin
          next_state = sdram_pkg::st_idle;
        end
      end
      sdram_pkg::st_idle: begin
        if (should_refresh) begin
          next_state = sdram_pkg::st_refresh;
          next_cmd   = sdram_pkg::cmd_auto_refresh;
        end else if (req) begin
          next_state = sdram_pkg::st_active;
          next_cmd   = sdram_pkg::cmd_active;
        end
      end
      sdram_pkg::st_active: begin
        if (active_done) begin
          next_state = we_reg ? sdram_pkg::st_write : sdram_pkg::st_read;
          next_cmd   = we_reg ? sdram_pkg::cmd_write : sdram_pkg::cmd_read;
        end
      end
      sdram_pkg::st_read, sdram_pkg::st_write: begin
        // refresh wins over a waiting request
        if (access_done) begin
          if (should_refresh) begin
            next_state = sdram_pkg::st_refresh;
            next_cmd   = sdram_pkg::cmd_auto_refresh;
          end else if (req) begin
            next_state = sdram_pkg::st_active;
            next_cmd   = sdram_pkg::cmd_active;
          end else begin
            next_state = sdram_pkg::st_idle;
          end
        end
      end
      sdram_pkg::st_refresh: begin
        if (refresh_done) begin
          if (req) begin
            next_state = sdram_pkg::st_active;
            next_cmd   = sdram_pkg::cmd_active;
          end else begin
            next_state = sdram_pkg::st_idle;
          end
        end
      end
      default: next_state = sdram_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= sdram_pkg::st_init;
      cmd             <= sdram_pkg::cmd_nop;
      wait_counter    <= '0;
      refresh_counter <= '0;
      valid           <= 1'b0;
    end else begin
      state <= next_state;
      cmd   <= next_cmd;
      // restarts on every state change
      if (state != next_state) begin
        wait_counter <= '0;
      end else begin
        wait_counter <= wait_counter + 1'b1;
      end
      // interval counts from the last refresh, held during init
      if (state == sdram_pkg::st_init || state == sdram_pkg::st_mode ||
          next_cmd == sdram_pkg::cmd_auto_refresh) begin
        refresh_counter <= '0;
      end else begin
        refresh_counter <= refresh_counter + 1'b1;
      end
      valid <= state == sdram_pkg::st_read && read_done;
    end
  end

  // word address doubled into an even x16 address
  always_ff @(posedge clk) begin
    if (start) begin
      addr_reg <= {addr[sdram_pkg::dev_addr_width-2:0], 1'b0};
      data_reg <= data;
      we_reg   <= we;
    end
  end

  // low half-word arrives first, after cas latency
  always_ff @(posedge clk) begin
    if (state == sdram_pkg::st_read) begin
      if (first_word) begin
        q_reg[sdram_pkg::sdram_data_width-1:0] <= sdram_dq;
      end else if (read_done) begin
        q_reg[mem_port_pkg::data_width-1:sdram_pkg::sdram_data_width] <= sdram_dq;
      end
    end
  end

  // write beats: low half with the command, high half next cycle
  assign dq_oe    = state == sdram_pkg::st_write && int'(wait_counter) < sdram_pkg::burst_length;
  assign dq_out   = (wait_counter == '0) ? data_reg[sdram_pkg::sdram_data_width-1:0] :
                    data_reg[mem_port_pkg::data_width-1:sdram_pkg::sdram_data_width];
  assign sdram_dq = dq_oe ? dq_out : 'z;

  assign ack = state == sdram_pkg::st_active && wait_counter == '0;
  assign q   = q_reg;

  // clock disabled only in the first init cycle
  assign sdram_cke = !(state == sdram_pkg::st_init && wait_counter == '0);

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;

  always_comb begin
    case (state)
      sdram_pkg::st_active, sdram_pkg::st_read, sdram_pkg::st_write: sdram_ba = bank;
      default: sdram_ba = '0;
    endcase
  end

  always_comb begin
    case (state)
      sdram_pkg::st_init:   sdram_a = sdram_pkg::precharge_all_a;
      sdram_pkg::st_mode:   sdram_a = sdram_pkg::mode_reg;
      sdram_pkg::st_active: sdram_a = row;
      // a10 set for auto-precharge
      sdram_pkg::st_read, sdram_pkg::st_write: sdram_a = {3'b001, col};
      default: sdram_a = '0;
    endcase
  end

endmodule

// ==== verilog/port_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// round-robin arbiter for two client ports in front of one controller,
// read data steered back to the port that issued the read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module port_arbiter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_0,
  input  logic                                we_0,
  input  logic [mem_port_pkg::addr_width-1:0] addr_0,
  input  logic [mem_port_pkg::data_width-1:0] wdata_0,
  output logic                                ack_0,
  output logic                                valid_0,
  output logic [mem_port_pkg::data_width-1:0] rdata_0,
  input  logic                                req_1,
  input  logic                                we_1,
  input  logic [mem_port_pkg::addr_width-1:0] addr_1,
  input  logic [mem_port_pkg::data_width-1:0] wdata_1,
  output logic                                ack_1,
  output logic                                valid_1,
  output logic [mem_port_pkg::data_width-1:0] rdata_1,
  output logic                                req,
  output logic                                we,
  output logic [mem_port_pkg::addr_width-1:0] addr,
  output logic [mem_port_pkg::data_width-1:0] data,
  input  logic                                ack,
  input  logic                                valid,
  input  logic [mem_port_pkg::data_width-1:0] q
);

  logic [mem_port_pkg::num_ports-1:0] req_vec;
  mem_port_pkg::port_id_t rr_ptr, grant, pick, sel, owner;
  logic held;

  // last read word per port
  logic [mem_port_pkg::data_width-1:0] rdata_q [mem_port_pkg::num_ports];

  assign req_vec = {req_1, req_0};

  // pointer port first, otherwise the other one
  assign pick = req_vec[rr_ptr] ? rr_ptr : mem_port_pkg::port_id_t'(rr_ptr + 1'b1);
  // grant is frozen once the controller sees it
  assign sel  = held ? grant : pick;

  assign req  = req_vec[sel];
  assign we   = sel ? we_1 : we_0;
  assign addr = sel ? addr_1 : addr_0;
  assign data = sel ? wdata_1 : wdata_0;

  assign ack_0 = ack && sel == mem_port_pkg::port_id_t'(0);
  assign ack_1 = ack && sel == mem_port_pkg::port_id_t'(1);

  // owner still names the finishing read when the next ack lands
  assign valid_0 = valid && owner == mem_port_pkg::port_id_t'(0);
  assign valid_1 = valid && owner == mem_port_pkg::port_id_t'(1);
  assign rdata_0 = valid_0 ? q : rdata_q[0];
  assign rdata_1 = valid_1 ? q : rdata_q[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      held   <= 1'b0;
      grant  <= '0;
      rr_ptr <= '0;
      owner  <= '0;
    end else if (ack) begin
      held   <= 1'b0;
      rr_ptr <= mem_port_pkg::port_id_t'(sel + 1'b1);
      if (!we) begin
        owner <= sel;
      end
    end else if (req && !held) begin
      held  <= 1'b1;
      grant <= pick;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      rdata_q[owner] <= q;
    end
  end

endmodule

// ==== verilog/sdram_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// two-port 32-bit memory subsystem on one x16 sdram device
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdram_subsystem (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   req_0,
  input  logic                                   we_0,
  input  logic [mem_port_pkg::addr_width-1:0]    addr_0,
  input  logic [mem_port_pkg::data_width-1:0]    wdata_0,
  output logic                                   ack_0,
  output logic                                   valid_0,
  output logic [mem_port_pkg::data_width-1:0]    rdata_0,
  input  logic                                   req_1,
  input  logic                                   we_1,
  input  logic [mem_port_pkg::addr_width-1:0]    addr_1,
  input  logic [mem_port_pkg::data_width-1:0]    wdata_1,
  output logic                                   ack_1,
  output logic                                   valid_1,
  output logic [mem_port_pkg::data_width-1:0]    rdata_1,
  output logic [sdram_pkg::sdram_addr_width-1:0] sdram_a,
  output logic [sdram_pkg::sdram_bank_width-1:0] sdram_ba,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  output logic                                   sdram_cke,
  output logic                                   sdram_cs_n,
  output logic                                   sdram_ras_n,
  output logic                                   sdram_cas_n,
  output logic                                   sdram_we_n
);

  // arbiter to controller
  logic                                ctrl_req;
  logic                                ctrl_we;
  logic [mem_port_pkg::addr_width-1:0] ctrl_addr;
  logic [mem_port_pkg::data_width-1:0] ctrl_data;
  logic                                ctrl_ack;
  logic                                ctrl_valid;
  logic [mem_port_pkg::data_width-1:0] ctrl_q;

  port_arbiter arbiter_i (
    .clk     (clk),
    .reset   (reset),
    .req_0   (req_0),
    .we_0    (we_0),
    .addr_0  (addr_0),
    .wdata_0 (wdata_0),
    .ack_0   (ack_0),
    .valid_0 (valid_0),
    .rdata_0 (rdata_0),
    .req_1   (req_1),
    .we_1    (we_1),
    .addr_1  (addr_1),
    .wdata_1 (wdata_1),
    .ack_1   (ack_1),
    .valid_1 (valid_1),
    .rdata_1 (rdata_1),
    .req     (ctrl_req),
    .we      (ctrl_we),
    .addr    (ctrl_addr),
    .data    (ctrl_data),
    .ack     (ctrl_ack),
    .valid   (ctrl_valid),
    .q       (ctrl_q)
  );

  sdram_ctrl ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .req         (ctrl_req),
    .we          (ctrl_we),
    .addr        (ctrl_addr),
    .data        (ctrl_data),
    .ack         (ctrl_ack),
    .valid       (ctrl_valid),
    .q           (ctrl_q),
    .sdram_a     (sdram_a),
    .sdram_ba    (sdram_ba),
    .sdram_dq    (sdram_dq),
    .sdram_cke   (sdram_cke),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n)
  );

endmodule

// ==== test/sdram_model.sv ====
////////////////////////////////////////////////////////////////////////////
// behavioral x16 sdram: command decode, cas latency two, burst of two,
// words kept in a sparse array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdram_model (
  input  logic                                   clk,
  input  logic [sdram_pkg::sdram_addr_width-1:0] sdram_a,
  input  logic [sdram_pkg::sdram_bank_width-1:0] sdram_ba,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  input  logic                                   sdram_cke,
  input  logic                                   sdram_cs_n,
  input  logic                                   sdram_ras_n,
  input  logic                                   sdram_cas_n,
  input  logic                                   sdram_we_n
);

  logic [sdram_pkg::sdram_data_width-1:0] mem [int];
  // row opened by the last active, one per bank
  logic [sdram_pkg::sdram_row_width-1:0]  open_row [4];
  sdram_pkg::sdram_cmd_e                  cmd;
  logic [sdram_pkg::dev_addr_width-1:0]   rd_addr;
  logic [sdram_pkg::dev_addr_width-1:0]   wr_addr;
  logic [1:0]                             rd_stage = 2'd0;
  logic                                   wr_second = 1'b0;
  logic                                   dq_oe = 1'b0;
  logic [sdram_pkg::sdram_data_width-1:0] dq_drv;

  assign cmd      = sdram_pkg::sdram_cmd_e'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});
  assign sdram_dq = dq_oe ? dq_drv : 'z;

  // unwritten locations read as zero
  function automatic logic [sdram_pkg::sdram_data_width-1:0] read_word(
      input logic [sdram_pkg::dev_addr_width-1:0] a);
    return mem.exists(int'(a)) ? mem[int'(a)] : '0;
  endfunction

  always @(posedge clk) begin
    wr_second <= 1'b0;
    // second write beat follows the command by one cycle
    if (wr_second) begin
      mem[int'(wr_addr)] = sdram_dq;
    end
    // read data: low word two edges after the command, high word next
    case (rd_stage)
      2'd1: begin
        dq_oe    <= 1'b1;
        dq_drv   <= read_word(rd_addr);
        rd_stage <= 2'd2;
      end
      2'd2: begin
        dq_drv   <= read_word(rd_addr + 1'b1);
        rd_stage <= 2'd3;
      end
      2'd3: begin
        dq_oe    <= 1'b0;
        rd_stage <= 2'd0;
      end
      default: ;
    endcase
    if (sdram_cke) begin
      case (cmd)
        sdram_pkg::cmd_active: open_row[sdram_ba] <= sdram_a;
        sdram_pkg::cmd_read: begin
          rd_addr  <= {sdram_ba, open_row[sdram_ba], sdram_a[sdram_pkg::sdram_col_width-1:0]};
          rd_stage <= 2'd1;
        end
        sdram_pkg::cmd_write: begin
          mem[int'({sdram_ba, open_row[sdram_ba], sdram_a[sdram_pkg::sdram_col_width-1:0]})] =
              sdram_dq;
          wr_addr   <= {sdram_ba, open_row[sdram_ba], sdram_a[sdram_pkg::sdram_col_width-1:0]}
                       + 1'b1;
          wr_second <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== test/sdram_asserts.sv ====
////////////////////////////////////////////////////////////////////////////
// command timing checks bound into the sdram controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdram_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  sdram_cke,
  input sdram_pkg::sdram_cmd_e cmd
);

  // cycles since the last refresh and active commands, saturating
  int since_refresh;
  int since_active;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_refresh <= sdram_pkg::refresh_wait;
      since_active  <= sdram_pkg::active_wait + 1;
    end else begin
      if (cmd == sdram_pkg::cmd_auto_refresh) begin
        since_refresh <= 1;
      end else if (since_refresh < sdram_pkg::refresh_wait) begin
        since_refresh <= since_refresh + 1;
      end
      if (cmd == sdram_pkg::cmd_active) begin
        since_active <= 1;
      end else if (since_active <= sdram_pkg::active_wait) begin
        since_active <= since_active + 1;
      end
    end
  end

  cke_rises: assert property (@(posedge clk) disable iff (reset)
    !sdram_cke |=> sdram_cke)
    else $error("cke stayed low after the first cycle");

  // read or write only exactly active_wait cycles after an active
  active_gap: assert property (@(posedge clk) disable iff (reset)
    (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write) |->
      since_active == sdram_pkg::active_wait)
    else $error("read or write issued without a preceding active");

  active_to_access: assert property (@(posedge clk) disable iff (reset)
    since_active == sdram_pkg::active_wait |->
      (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write))
    else $error("active not followed by read or write");

  refresh_quiet: assert property (@(posedge clk) disable iff (reset)
    since_refresh < sdram_pkg::refresh_wait |-> cmd == sdram_pkg::cmd_nop)
    else $error("command issued inside a refresh");

endmodule

bind sdram_ctrl sdram_asserts asserts_i (
  .clk       (clk),
  .reset     (reset),
  .sdram_cke (sdram_cke),
  .cmd       (cmd)
);

// ==== test/sdram_subsystem_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the two-port sdram subsystem, driven from a case file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdram_subsystem_tb;

  localparam int ack_timeout   = 6000;
  localparam int valid_timeout = 50;
  // earliest first ack after reset release
  localparam int init_min = sdram_pkg::init_wait + sdram_pkg::precharge_wait +
                            2 * sdram_pkg::refresh_wait + sdram_pkg::load_mode_wait;

  logic clk;
  logic reset;
  logic req_0, we_0, ack_0, valid_0;
  logic req_1, we_1, ack_1, valid_1;
  logic [mem_port_pkg::addr_width-1:0]    addr_0, addr_1;
  logic [mem_port_pkg::data_width-1:0]    wdata_0, wdata_1, rdata_0, rdata_1;
  logic [sdram_pkg::sdram_addr_width-1:0] sdram_a;
  logic [sdram_pkg::sdram_bank_width-1:0] sdram_ba;
  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq;
  logic sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;

  // sparse reference memory, updated at each write ack
  logic [mem_port_pkg::data_width-1:0] ref_mem [int];
  mem_port_pkg::port_id_t ack_order [$];
  // round-robin pointer starts at port 0, so port 1 counts as served last
  mem_port_pkg::port_id_t last_port = 1'b1;
  int  cycles;
  int  seed;

  // case file columns
  string       names [$];
  string       ops [$];
  int          ports [$];
  int          gaps [$];
  logic [31:0] addrs [$];
  logic [31:0] datas [$];

  sdram_subsystem dut_i (.*);

  sdram_model model_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_data(input string name, input logic [mem_port_pkg::data_width-1:0] expected,
                            input logic [mem_port_pkg::data_width-1:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_port(input string name, input mem_port_pkg::port_id_t expected,
                            input mem_port_pkg::port_id_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s expected port %0d actual port %0d", name, expected, actual));
    end
  endtask

  // no ack and no read data on either port before the init sequence has ended
  always @(negedge clk) begin
    if (!reset && cycles < init_min && (ack_0 || ack_1 || valid_0 || valid_1)) begin
      stop_run("ack or valid pulsed before the init sequence finished");
    end
  end

  task automatic drive_port(input mem_port_pkg::port_id_t port, input logic req, input logic we,
                            input logic [mem_port_pkg::addr_width-1:0] a,
                            input logic [mem_port_pkg::data_width-1:0] d);
    if (port) begin
      req_1 = req;
      we_1 = we;
      addr_1 = a;
      wdata_1 = d;
    end else begin
      req_0 = req;
      we_0 = we;
      addr_0 = a;
      wdata_0 = d;
    end
  endtask

  // one access on one port; reads wait for valid and are compared
  task automatic run_access(input int idx);
    mem_port_pkg::port_id_t              port;
    logic [mem_port_pkg::addr_width-1:0] a;
    logic [mem_port_pkg::data_width-1:0] d;
    logic [mem_port_pkg::data_width-1:0] expected;
    bit write;
    bit seen;
    int waited;
    port = mem_port_pkg::port_id_t'(ports[idx]);
    a = addrs[idx][mem_port_pkg::addr_width-1:0];
    write = ops[idx] != "r";
    d = (ops[idx] == "f") ? $random(seed) : datas[idx];
    drive_port(port, 1'b1, write, a, d);
    seen = 1'b0;
    waited = 0;
    while (!seen) begin
      @(negedge clk);
      seen = port ? ack_1 : ack_0;
      waited++;
      if (!seen && waited > ack_timeout) begin
        stop_run($sformatf("%s: no ack on port %0d", names[idx], port));
      end
    end
    ack_order.push_back(port);
    last_port = port;
    drive_port(port, 1'b0, write, a, d);
    if (write) begin
      ref_mem[int'(a)] = d;
    end else begin
      if (!ref_mem.exists(int'(a))) begin
        stop_run($sformatf("%s: case file reads an address never written", names[idx]));
      end
      expected = ref_mem[int'(a)];
      seen = 1'b0;
      waited = 0;
      while (!seen) begin
        @(negedge clk);
        seen = port ? valid_1 : valid_0;
        waited++;
        if (!seen && waited > valid_timeout) begin
          stop_run($sformatf("%s: no valid on port %0d", names[idx], port));
        end
      end
      check_data(names[idx], expected, port ? rdata_1 : rdata_0);
    end
  endtask

  initial begin
    int                     fd;
    int                     i;
    int                     p;
    int                     g;
    string                  line;
    string                  nm;
    string                  op;
    logic [31:0]            a;
    logic [31:0]            d;
    mem_port_pkg::port_id_t exp_first;
    seed = 32'h968f;
    reset = 1'b1;
    drive_port(0, 1'b0, 1'b0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0);
    fd = $fopen("test/sdram_cases.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open test/sdram_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        if ($sscanf(line, "%s %d %s %h %h %d", nm, p, op, a, d, g) == 6) begin
          names.push_back(nm);
          ports.push_back(p);
          ops.push_back(op);
          addrs.push_back(a);
          datas.push_back(d);
          gaps.push_back(g);
        end
      end
    end
    $fclose(fd);
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    i = 0;
    while (i < names.size()) begin
      ack_order.delete();
      // a zero gap launches the next line on the other port together
      if (gaps[i] == 0 && i + 1 < names.size() && ports[i] != ports[i + 1]) begin
        // the port not served last wins when both ask at once
        exp_first = mem_port_pkg::port_id_t'(~last_port);
        fork
          run_access(i);
          run_access(i + 1);
        join
        check_port(names[i], exp_first, ack_order[0]);
        i += 1;
      end else begin
        run_access(i);
      end
      repeat (gaps[i]) @(negedge clk);
      i += 1;
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== test/sdram_cases.txt ====
# columns: test port op addr data gap (op w write, f write random fill, r read)
# addr and data in hex, gap in idle cycles; gap 0 starts the next line with this one
first_ack      0 w 000010 a5a51234 2
wr_rd_p0       0 r 000010 00000000 2
wr_p1          1 w 000020 0badcafe 2
wr_rd_p1       1 r 000020 00000000 2
fill_pair      0 f 000100 00000000 0
fill_pair      1 f 000104 00000000 3
both_read      0 r 000100 00000000 0
both_read      1 r 000104 00000000 3
both_write     0 w 000300 11112222 0
both_write     1 w 000301 33334444 3
both_cross     0 r 000301 00000000 0
both_cross     1 r 000300 00000000 3
map_base       0 f 000040 00000000 1
map_row        0 f 000240 00000000 1
map_bank       1 f 400040 00000000 1
map_rowbank    1 f c3fe40 00000000 1
map_chk        0 r 000040 00000000 0
map_chk        1 r 400040 00000000 1
map_chk_row    1 r 000240 00000000 1
map_chk_rb     0 r c3fe40 00000000 500
after_refresh  0 r 000010 00000000 1
after_ref_bank 1 r 400040 00000000 1

// ==== flist.f ====
verilog/sdram_pkg.sv
verilog/mem_port_pkg.sv
verilog/sdram_ctrl.sv
verilog/port_arbiter.sv
verilog/sdram_subsystem.sv
test/sdram_model.sv
test/sdram_asserts.sv
test/sdram_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module sdram_subsystem_tb -f flist.f -o sim_tb &&
./obj_dir/sim_tb || exit 1
